/* rtl/fb_defines.svh */
// Framebuffer readout widths
// Bus, address, pixel and count sizes shared by the readout blocks
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// Width of one memory beat in bits
`define FB_STREAM_WIDTH 32

// Width of a byte address into the framebuffer
`define FB_ADDR_WIDTH 24

// Width of one stored pixel in RGB565
`define FB_PIXEL_WIDTH 16

// Width of the pixel count of one run
`define FB_COUNT_WIDTH 16

// Bytes covered by one memory line
`define FB_LINE_BYTES (`FB_STREAM_WIDTH / 8)

// Bytes taken by one stored pixel
`define FB_PIXEL_BYTES (`FB_PIXEL_WIDTH / 8)

// Pixels packed into one memory line
`define FB_PIXELS_PER_LINE (`FB_STREAM_WIDTH / `FB_PIXEL_WIDTH)

`endif

/* rtl/framebufferPkg.sv */
// Framebuffer readout types
// Memory line views and the expanded output pixel
`include "fb_defines.svh"

package framebufferPkg;

    ////////////////////
    // Memory line
    ////////////////////

    // One memory beat, seen either as the raw bus word or as its pixels
    // Pixel 0 sits in the low half and belongs to the lower address
    typedef union packed
    {
        logic [`FB_STREAM_WIDTH-1:0] raw;
        logic [`FB_PIXELS_PER_LINE-1:0][`FB_PIXEL_WIDTH-1:0] pixel;
    } memLine;

    ////////////////////
    // Output pixel
    ////////////////////

    // Expanded true color pixel, red in the top byte
    typedef struct packed
    {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb888;

endpackage

/* rtl/ReadoutFetcher.sv */
// Readout fetcher
// Turns a start strobe into line read addresses and one fetch request per pixel
`timescale 1ns/1ps
`include "fb_defines.svh"

module ReadoutFetcher
(
    input  logic                         aclk,
    input  logic                         resetn,

    // Run request
    input  logic                         start,
    input  logic [`FB_ADDR_WIDTH-1:0]    startAddr,
    input  logic [`FB_COUNT_WIDTH-1:0]   pixelCount,
    output logic                         idle,

    // Read address channel
    output logic                         arvalid,
    input  logic                         arready,
    output logic [`FB_ADDR_WIDTH-1:0]    araddr,

    // Per pixel fetch stream
    output logic                         fetchValid,
    input  logic                         fetchReady,
    output logic [`FB_ADDR_WIDTH-1:0]    fetchAddr,
    output logic                         fetchLast
);
    localparam int LINE_LSB = $clog2(`FB_LINE_BYTES);
    localparam int PIXEL_LSB = $clog2(`FB_PIXEL_BYTES);

    // Line address of the final pixel of the run
    logic [`FB_ADDR_WIDTH-1:0]  lastLine;
    // Pixels still to come after the one on fetchAddr
    logic [`FB_COUNT_WIDTH-1:0] remaining;

    logic                       accept;
    logic [`FB_ADDR_WIDTH-1:0]  firstPixel;
    logic [`FB_ADDR_WIDTH-1:0]  lastPixel;

    // The readout is busy as long as either counter still has work
    assign idle = !fetchValid && !arvalid;

    // An empty run is ignored
    assign accept = idle && start && (pixelCount != '0);

    always_comb
    begin
        // Drop the byte offset inside a pixel
        firstPixel = startAddr;
        firstPixel[PIXEL_LSB-1:0] = '0;
        // Step over count - 1 pixels to reach the final one
        lastPixel = firstPixel
            + (`FB_ADDR_WIDTH'(pixelCount - 1'b1) << PIXEL_LSB);
    end

    ////////////////////
    // Line counter
    ////////////////////

    // Walks the lines from the start line through the last line, independent of
    // the fetches, so reads can run ahead of the pixel stream
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            arvalid <= 1'b0;
        end
        else if (accept)
        begin
            arvalid <= 1'b1;
            araddr <= {firstPixel[`FB_ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
            lastLine <= {lastPixel[`FB_ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
        end
        else if (arvalid && arready)
        begin
            if (araddr == lastLine)
            begin
                // Final line handed to memory
                arvalid <= 1'b0;
            end
            else
            begin
                araddr <= araddr + `FB_ADDR_WIDTH'(`FB_LINE_BYTES);
            end
        end
    end

    ////////////////////
    // Pixel counter
    ////////////////////

    // One fetch per pixel, the last one flagged
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            fetchValid <= 1'b0;
            fetchLast <= 1'b0;
        end
        else if (accept)
        begin
            fetchValid <= 1'b1;
            fetchAddr <= firstPixel;
            fetchLast <= (pixelCount == `FB_COUNT_WIDTH'(1));
            remaining <= pixelCount - 1'b1;
        end
        else if (fetchValid && fetchReady)
        begin
            if (fetchLast)
            begin
                // Run done, idle follows on the next cycle
                fetchValid <= 1'b0;
                fetchLast <= 1'b0;
            end
            else
            begin
                fetchAddr <= fetchAddr + `FB_ADDR_WIDTH'(`FB_PIXEL_BYTES);
                remaining <= remaining - 1'b1;
                fetchLast <= (remaining == `FB_COUNT_WIDTH'(1));
            end
        end
    end

    // Memory only ever sees whole lines
    assert property (@(posedge aclk) disable iff (!resetn)
        arvalid |-> (araddr[LINE_LSB-1:0] == '0));

endmodule

/* rtl/FramebufferSerializer.sv */
// Framebuffer serializer
// Serves pixel fetches from a one-line cache or from the next memory beat
`timescale 1ns/1ps
`include "fb_defines.svh"

module FramebufferSerializer import framebufferPkg::*;
(
    input  logic                         aclk,
    input  logic                         resetn,

    // Fetch requests
    input  logic                         fetchValid,
    output logic                         fetchReady,
    input  logic [`FB_ADDR_WIDTH-1:0]    fetchAddr,
    input  logic                         fetchLast,

    // Read data channel
    input  logic                         rvalid,
    output logic                         rready,
    input  logic [`FB_STREAM_WIDTH-1:0]  rdata,

    // Pixel fragments
    output logic                         fragValid,
    input  logic                         fragReady,
    output logic [`FB_PIXEL_WIDTH-1:0]   fragData,
    output logic [`FB_ADDR_WIDTH-1:0]    fragAddr,
    output logic                         fragLast
);
    localparam int LINE_LSB = $clog2(`FB_LINE_BYTES);
    localparam int PIXEL_LSB = $clog2(`FB_PIXEL_BYTES);
    localparam int TAG_WIDTH = `FB_ADDR_WIDTH - LINE_LSB;
    localparam int POS_WIDTH = LINE_LSB - PIXEL_LSB;

    ////////////////////
    // Cache and skid
    ////////////////////

    // Last line read from memory and the line address it belongs to
    memLine                     cacheLine;
    logic [TAG_WIDTH-1:0]       cacheTag;
    logic                       cacheTagValid;

    // Fetch parked while the output or the memory stalls
    logic                       skid;
    logic [`FB_ADDR_WIDTH-1:0]  skidAddr;
    logic                       skidLast;

    // Incoming beat, decoded as pixels
    memLine                     beat;

    // Request under service this cycle
    logic                       reqValid;
    logic [`FB_ADDR_WIDTH-1:0]  reqAddr;
    logic                       reqLast;
    logic [TAG_WIDTH-1:0]       reqTag;
    logic [POS_WIDTH-1:0]       reqPos;

    logic                       hit;
    logic                       beatReady;
    logic                       outFree;
    logic                       serve;

    always_comb
    begin
        beat.raw = rdata;
    end

    // New fetches are taken only while nothing waits in the skid register
    assign fetchReady = !skid;

    // A parked fetch has priority over the fetch port
    assign reqValid = skid || fetchValid;
    assign reqAddr = skid ? skidAddr : fetchAddr;
    assign reqLast = skid ? skidLast : fetchLast;
    assign reqTag = reqAddr[`FB_ADDR_WIDTH-1:LINE_LSB];
    assign reqPos = reqAddr[LINE_LSB-1:PIXEL_LSB];

    assign hit = cacheTagValid && (cacheTag == reqTag);

    // While rready is high the beat on rdata is the one already captured and
    // being popped, so a second miss in that cycle has to wait a bubble
    assign beatReady = rvalid && !rready;

    // The fragment register can load when empty or when its content leaves now
    assign outFree = !fragValid || fragReady;

    assign serve = reqValid && outFree && (hit || beatReady);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            fragValid <= 1'b0;
            fragLast <= 1'b0;
            rready <= 1'b0;
            skid <= 1'b0;
            cacheTagValid <= 1'b0;
        end
        else
        begin
            // rready is a single cycle pulse that pops a captured beat
            rready <= 1'b0;

            if (serve)
            begin
                skid <= 1'b0;
                fragValid <= 1'b1;
                fragAddr <= reqAddr;
                fragLast <= reqLast;

                if (hit)
                begin
                    fragData <= cacheLine.pixel[reqPos];
                end
                else
                begin
                    // Fast fetch
                    // Take the pixel straight from rdata and pop the beat next cycle
                    fragData <= beat.pixel[reqPos];
                    cacheLine.raw <= rdata;
                    cacheTag <= reqTag;
                    rready <= 1'b1;
                end

                // Forget the line after the last pixel so the next run misses first
                cacheTagValid <= !reqLast;
            end
            else
            begin
                // The old fragment leaves or the register was already empty
                if (outFree)
                begin
                    fragValid <= 1'b0;
                end

                // Park a fetch that could not be served this cycle
                if (!skid && fetchValid)
                begin
                    skid <= 1'b1;
                    skidAddr <= fetchAddr;
                    skidLast <= fetchLast;
                end
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A parked fetch only produces a fragment once its data is at hand
    assert property (@(posedge aclk) disable iff (!resetn)
        (skid && !hit && !rvalid) |=> !$rose(fragValid));

    // Every popped beat is followed by at least one cycle without rready
    assert property (@(posedge aclk) disable iff (!resetn)
        rready |=> !rready);

endmodule

/* rtl/PixelFormatter.sv */
// Pixel formatter
// Expands RGB565 fragments to RGB888 in a one-entry output register
`timescale 1ns/1ps
`include "fb_defines.svh"

module PixelFormatter import framebufferPkg::*;
(
    input  logic                         aclk,
    input  logic                         resetn,

    // Fragments from the serializer
    input  logic                         fragValid,
    output logic                         fragReady,
    input  logic [`FB_PIXEL_WIDTH-1:0]   fragData,
    input  logic [`FB_ADDR_WIDTH-1:0]    fragAddr,
    input  logic                         fragLast,

    // Pixel output
    output logic                         pixValid,
    input  logic                         pixReady,
    output rgb888                        pixColor,
    output logic [`FB_ADDR_WIDTH-1:0]    pixAddr,
    output logic                         pixLast
);
    // Expanded color of the incoming fragment
    rgb888 expanded;

    // Each field is shifted up and its top bits refill the low bits,
    // so full scale maps to 8'hff and zero stays zero
    always_comb
    begin
        expanded.red = {fragData[15:11], fragData[15:13]};
        expanded.green = {fragData[10:5], fragData[10:9]};
        expanded.blue = {fragData[4:0], fragData[4:2]};
    end

    // Ready when empty or when the held pixel is taken this cycle
    assign fragReady = !pixValid || pixReady;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            pixValid <= 1'b0;
            pixLast <= 1'b0;
        end
        else if (fragReady)
        begin
            pixValid <= fragValid;
            if (fragValid)
            begin
                pixColor <= expanded;
                pixAddr <= fragAddr;
                pixLast <= fragLast;
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // A stalled pixel keeps color, address and last flag until it is taken
    assert property (@(posedge aclk) disable iff (!resetn)
        (pixValid && !pixReady) |=> (pixValid && $stable(pixColor)
            && $stable(pixAddr) && $stable(pixLast)));

endmodule

/* rtl/FramebufferReadout.sv */
// Framebuffer readout top level
// Fetcher, serializer and formatter between the memory ports and the pixel stream
`timescale 1ns/1ps
`include "fb_defines.svh"

module FramebufferReadout import framebufferPkg::*;
(
    input  logic                         aclk,
    input  logic                         resetn,

    // Run request
    input  logic                         start,
    input  logic [`FB_ADDR_WIDTH-1:0]    startAddr,
    input  logic [`FB_COUNT_WIDTH-1:0]   pixelCount,
    output logic                         idle,

    // Read address channel
    output logic                         arvalid,
    input  logic                         arready,
    output logic [`FB_ADDR_WIDTH-1:0]    araddr,

    // Read data channel
    input  logic                         rvalid,
    output logic                         rready,
    input  logic [`FB_STREAM_WIDTH-1:0]  rdata,

    // Pixel output
    output logic                         pixValid,
    input  logic                         pixReady,
    output rgb888                        pixColor,
    output logic [`FB_ADDR_WIDTH-1:0]    pixAddr,
    output logic                         pixLast
);
    // Fetch stream between fetcher and serializer
    logic                       fetchValid;
    logic                       fetchReady;
    logic [`FB_ADDR_WIDTH-1:0]  fetchAddr;
    logic                       fetchLast;

    // Raw pixel stream between serializer and formatter
    logic                       fragValid;
    logic                       fragReady;
    logic [`FB_PIXEL_WIDTH-1:0] fragData;
    logic [`FB_ADDR_WIDTH-1:0]  fragAddr;
    logic                       fragLast;

    ReadoutFetcher u_fetcher
    (
        .aclk       (aclk),
        .resetn     (resetn),
        .start      (start),
        .startAddr  (startAddr),
        .pixelCount (pixelCount),
        .idle       (idle),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchAddr  (fetchAddr),
        .fetchLast  (fetchLast)
    );

    FramebufferSerializer u_serializer
    (
        .aclk       (aclk),
        .resetn     (resetn),
        .fetchValid (fetchValid),
        .fetchReady (fetchReady),
        .fetchAddr  (fetchAddr),
        .fetchLast  (fetchLast),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .fragValid  (fragValid),
        .fragReady  (fragReady),
        .fragData   (fragData),
        .fragAddr   (fragAddr),
        .fragLast   (fragLast)
    );

    PixelFormatter u_formatter
    (
        .aclk       (aclk),
        .resetn     (resetn),
        .fragValid  (fragValid),
        .fragReady  (fragReady),
        .fragData   (fragData),
        .fragAddr   (fragAddr),
        .fragLast   (fragLast),
        .pixValid   (pixValid),
        .pixReady   (pixReady),
        .pixColor   (pixColor),
        .pixAddr    (pixAddr),
        .pixLast    (pixLast)
    );

endmodule

/* dv/tbMemory.sv */
// Testbench memory model
// Answers line reads in order, with data from a fill formula after a random delay
`timescale 1ns/1ps
`include "fb_defines.svh"

module tbMemory
(
    input  logic                         aclk,
    input  logic                         resetn,
    input  logic [3:0]                   maxDelay,

    // Read address channel
    input  logic                         arvalid,
    output logic                         arready,
    input  logic [`FB_ADDR_WIDTH-1:0]    araddr,

    // Read data channel
    output logic                         rvalid,
    input  logic                         rready,
    output logic [`FB_STREAM_WIDTH-1:0]  rdata,

    // High while any accepted read is still unanswered
    output logic                         busy
);
    logic                        arreadyReg = 1'b0;
    logic                        rvalidReg = 1'b0;
    logic [`FB_STREAM_WIDTH-1:0] rdataReg = '0;
    logic [3:0]                  delayLeft = '0;
    logic [`FB_ADDR_WIDTH-1:0]   addrQ[$];
    int                          pending = 0;

    // Fill formula, mixes every address bit into the word
    function automatic logic [31:0] lineWord(input logic [`FB_ADDR_WIDTH-1:0] addr);
        logic [31:0] x;
        x = {8'h00, addr};
        return (x * 32'h9E37_79B9) ^ (x << 8);
    endfunction

    assign arready = arreadyReg;
    assign rvalid = rvalidReg;
    assign rdata = rdataReg;
    assign busy = rvalidReg || (pending != 0);

    always @(posedge aclk)
    begin
        if (!resetn)
        begin
            arreadyReg <= 1'b0;
            rvalidReg <= 1'b0;
            delayLeft <= '0;
            addrQ.delete();
            pending = 0;
        end
        else
        begin
            // The beat slot is free when empty or when its beat is popped now
            if (!rvalidReg || rready)
            begin
                if (addrQ.size() != 0 && delayLeft == 4'd0)
                begin
                    rvalidReg <= 1'b1;
                    rdataReg <= lineWord(addrQ.pop_front());
                    delayLeft <= 4'($urandom_range(0, maxDelay));
                end
                else
                begin
                    rvalidReg <= 1'b0;
                    // Count the delay down only while a read waits
                    if (delayLeft != 4'd0 && addrQ.size() != 0)
                        delayLeft <= delayLeft - 4'd1;
                end
            end
            if (arvalid && arreadyReg)
                addrQ.push_back(araddr);
            // Address stalls appear only when memory is slowed down
            arreadyReg <= (maxDelay == 4'd0) || ($urandom_range(0, 3) != 0);
            pending = addrQ.size();
        end
    end

endmodule

/* dv/tb_FramebufferReadout.sv */
// Framebuffer readout testbench
// Runs pixel reads against the memory model and checks every pixel against a reference
`timescale 1ns/1ps
`include "fb_defines.svh"

module tb_FramebufferReadout
    import framebufferPkg::*;
();
    // Pixel counts of the five runs below
    localparam int TOTAL_PIXELS = 16 + 9 + 24 + 21 + 32;
    localparam int CYCLE_LIMIT = 20 * TOTAL_PIXELS + 200;

    logic                        aclk;
    logic                        resetn;
    logic                        start;
    logic [`FB_ADDR_WIDTH-1:0]   startAddr;
    logic [`FB_COUNT_WIDTH-1:0]  pixelCount;
    logic                        idle;
    logic                        arvalid;
    logic                        arready;
    logic [`FB_ADDR_WIDTH-1:0]   araddr;
    logic                        rvalid;
    logic                        rready;
    logic [`FB_STREAM_WIDTH-1:0] rdata;
    logic                        pixValid;
    logic                        pixReady = 1'b0;
    rgb888                       pixColor;
    logic [`FB_ADDR_WIDTH-1:0]   pixAddr;
    logic                        pixLast;

    // Run controls
    logic [3:0]                  memDelay;
    logic                        readyRandom;
    logic                        memBusy;
    string                       testName = "reset";

    // Scoreboard state
    logic [`FB_ADDR_WIDTH-1:0]   expectQ[$];
    logic                        lastSeen = 1'b0;
    logic                        heldValid = 1'b0;
    rgb888                       heldColor;
    logic [`FB_ADDR_WIDTH-1:0]   heldAddr;
    logic                        heldLast;
    int colorErrors = 0;
    int addrErrors = 0;
    int lastErrors = 0;
    int otherErrors = 0;
    int pixelsChecked = 0;
    int cycles = 0;

    FramebufferReadout u_dut
    (
        .aclk(aclk), .resetn(resetn), .start(start), .startAddr(startAddr),
        .pixelCount(pixelCount), .idle(idle),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .pixValid(pixValid), .pixReady(pixReady), .pixColor(pixColor),
        .pixAddr(pixAddr), .pixLast(pixLast)
    );

    tbMemory u_mem
    (
        .aclk(aclk), .resetn(resetn), .maxDelay(memDelay),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .busy(memBusy)
    );

    always #20 aclk = ~aclk;

    ////////////////////
    // Reference
    ////////////////////

    // Same fill formula as the memory model
    function automatic logic [31:0] lineWord(input logic [`FB_ADDR_WIDTH-1:0] addr);
        logic [31:0] x;
        x = {8'h00, addr};
        return (x * 32'h9E37_79B9) ^ (x << 8);
    endfunction

    // Pick the 565 pixel out of its line and widen each field
    // Each field moves to the top of its byte and its leading bits fill the gap below
    function automatic rgb888 expectedColor(input logic [`FB_ADDR_WIDTH-1:0] addr);
        logic [31:0] word;
        logic [15:0] px;
        logic [4:0]  red5;
        logic [5:0]  green6;
        logic [4:0]  blue5;
        rgb888       color;
        word = lineWord({addr[`FB_ADDR_WIDTH-1:2], 2'b00});
        // Upper half of the line holds the pixel at the higher address
        px = addr[1] ? word[31:16] : word[15:0];
        red5 = px[15:11];
        green6 = px[10:5];
        blue5 = px[4:0];
        color.red = (8'(red5) << 3) | 8'(red5 >> 2);
        color.green = (8'(green6) << 2) | 8'(green6 >> 4);
        color.blue = (8'(blue5) << 3) | 8'(blue5 >> 2);
        return color;
    endfunction

    task automatic compareColor(input string test, input rgb888 expected, input rgb888 actual);
        if (expected !== actual)
        begin
            colorErrors++;
            $display("error %s color expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic compareAddr(input string test, input logic [`FB_ADDR_WIDTH-1:0] expected,
                               input logic [`FB_ADDR_WIDTH-1:0] actual);
        if (expected !== actual)
        begin
            addrErrors++;
            $display("error %s address expected %h actual %h", test, expected, actual);
        end
    endtask

    task automatic compareLast(input string test, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            lastErrors++;
            $display("error %s last flag expected %b actual %b", test, expected, actual);
        end
    endtask

    ////////////////////
    // Compare process
    ////////////////////

    // Sampled at the falling edge where handshake and data are settled
    always @(negedge aclk)
    begin : compare
        logic [`FB_ADDR_WIDTH-1:0] expAddr;
        logic                      expLast;
        if (resetn)
        begin
            // A stalled pixel has to come back unchanged
            if (heldValid && !(pixValid && pixColor === heldColor && pixAddr === heldAddr
                               && pixLast === heldLast))
            begin
                otherErrors++;
                $display("%s: stalled pixel at %h changed before it was taken",
                         testName, heldAddr);
            end
            if (pixValid && pixReady)
            begin
                if (expectQ.size() == 0)
                begin
                    otherErrors++;
                    $display("%s: extra pixel at %h arrived after the run", testName, pixAddr);
                end
                else
                begin
                    // Only the final pixel of a run may carry the last flag
                    expLast = (expectQ.size() == 1);
                    expAddr = expectQ.pop_front();
                    compareAddr(testName, expAddr, pixAddr);
                    compareColor(testName, expectedColor(expAddr), pixColor);
                    compareLast(testName, expLast, pixLast);
                    pixelsChecked++;
                end
                if (pixLast)
                    lastSeen = 1'b1;
            end
            heldValid = pixValid && !pixReady;
            heldColor = pixColor;
            heldAddr = pixAddr;
            heldLast = pixLast;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    // Output back-pressure is random only in the runs that ask for it
    always @(posedge aclk)
    begin
        pixReady <= resetn && (!readyRandom || ($urandom_range(0, 1) == 0));
    end

    // One readout run queues the expected pixels and waits until all are out
    task automatic runReadout(input string name, input logic [`FB_ADDR_WIDTH-1:0] addr,
                              input int count, input logic [3:0] delay, input logic randomReady);
        logic [`FB_ADDR_WIDTH-1:0] pixel;
        testName = name;
        lastSeen = 1'b0;
        pixel = {addr[`FB_ADDR_WIDTH-1:1], 1'b0};
        for (int i = 0; i < count; i++)
        begin
            expectQ.push_back(pixel);
            pixel = pixel + `FB_ADDR_WIDTH'(2);
        end
        // The readout has to report idle before it is started
        @(negedge aclk);
        if (idle !== 1'b1)
        begin
            otherErrors++;
            $display("%s: readout was not idle before the start strobe", name);
        end
        @(posedge aclk);
        memDelay <= delay;
        readyRandom <= randomReady;
        start <= 1'b1;
        startAddr <= addr;
        pixelCount <= `FB_COUNT_WIDTH'(count);
        @(posedge aclk);
        start <= 1'b0;
        // The run is busy from the cycle after the start strobe
        @(negedge aclk);
        if (idle !== 1'b0)
        begin
            otherErrors++;
            $display("%s: idle stayed high after the start strobe", name);
        end
        // Wait for the final pixel and then for idle
        while (!lastSeen)
            @(posedge aclk);
        while (!idle)
            @(posedge aclk);
        @(negedge aclk);
        if (expectQ.size() != 0)
        begin
            otherErrors++;
            $display("%s: run ended with %0d pixels missing", name, expectQ.size());
            expectQ.delete();
        end
        if (memBusy)
        begin
            otherErrors++;
            $display("%s: memory still holds unread lines after the run", name);
        end
    endtask

    initial
    begin
        void'($urandom(32'h7399_302e));
        aclk = 1'b0;
        resetn = 1'b0;
        start = 1'b0;
        startAddr = '0;
        pixelCount = '0;
        memDelay = 4'd0;
        readyRandom = 1'b0;
        repeat (2) @(posedge aclk);
        resetn <= 1'b1;

        runReadout("alignedRun", 24'h001000, 16, 4'd0, 1'b0);
        // Starts in the line the first run ended in, so a stale tag would show
        runReadout("oddStartRun", 24'h00101E, 9, 4'd0, 1'b0);
        runReadout("stalledOutput", 24'h020400, 24, 4'd0, 1'b1);
        // Odd start puts the first two misses back to back
        runReadout("slowMemory", 24'h0307F2, 21, 4'd5, 1'b0);
        runReadout("mixedStall", 24'h04FFFE, 32, 4'd3, 1'b1);

        $display("checked %0d pixels, errors: color %0d address %0d last %0d other %0d",
                 pixelsChecked, colorErrors, addrErrors, lastErrors, otherErrors);
        if (colorErrors + addrErrors + lastErrors + otherErrors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // Limit scales with the pixels of all runs
    always @(posedge aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout, %s did not finish within %0d cycles", testName, CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

endmodule

/* build.f */
+incdir+rtl
rtl/framebufferPkg.sv
rtl/ReadoutFetcher.sv
rtl/FramebufferSerializer.sv
rtl/PixelFormatter.sv
rtl/FramebufferReadout.sv
dv/tbMemory.sv
dv/tb_FramebufferReadout.sv

/* Makefile */
# Verilator build and run of the framebuffer readout testbench

BIN := obj_dir/Vtb_FramebufferReadout

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): build.f $(wildcard rtl/*.sv rtl/*.svh dv/*.sv)
	verilator --binary --timing --assert -j 0 -f build.f \
		--top-module tb_FramebufferReadout -Mdir obj_dir -o Vtb_FramebufferReadout

# Passes only when the run prints the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
